//--- flist.f
+incdir+hw
hw/ddr_bridge_pkg.sv
hw/sync_fifo.sv
hw/wb_front.sv
hw/rd_line_buf.sv
hw/ddr_seq_ctrl.sv
hw/ddr_bridge_top.sv
verif/local_mem_model.sv
verif/tb_ddr_bridge.sv

//--- hw/ddr_bridge_consts.svh
`ifndef DDR_BRIDGE_CONSTS_SVH
`define DDR_BRIDGE_CONSTS_SVH

//////////////////////////////
// Bus side
//////////////////////////////

`define DDRB_ADDR_W      32   // Bus byte address

//////////////////////////////
// Queues
//////////////////////////////

`define DDRB_CMDQ_DEPTH  8    // Command entries, also the starting credit count
`define DDRB_RSPQ_DEPTH  2    // Returned lines, one read in flight at most

// Line address drops the 5 bits of byte-in-line offset
`define DDRB_LINE_AW     (`DDRB_ADDR_W - 5)

`endif

//--- hw/ddr_bridge_pkg.sv
`default_nettype none
`include "ddr_bridge_consts.svh"

package ddr_bridge_pkg;

   typedef logic [63:0]  word_t;   // One bus data word
   typedef logic [255:0] line_t;   // Four words, word 0 in bits 63:0
   typedef logic [7:0]   be_t;     // Byte enable of one word

   //////////////////////////////
   // Queued command
   //////////////////////////////

   typedef struct packed {
      logic                     is_write;
      logic [`DDRB_LINE_AW-1:0] line_addr;
      logic [1:0]               lane;       // Word within the line
      be_t                      be;
      word_t                    wdata;
   } ddr_cmd_t;

   //////////////////////////////
   // Bus request from the master
   //////////////////////////////

   typedef struct packed {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [`DDRB_ADDR_W-1:0]  adr;
      be_t                      sel;
      word_t                    dat;
   } wb_req_t;

endpackage

`default_nettype wire

//--- hw/ddr_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module ddr_bridge_top (
   input  wire                          ddr_clk,
   input  wire                          ddr_rst,
   input  wire ddr_bridge_pkg::wb_req_t wb_req_i,
   output wire ddr_bridge_pkg::word_t   wb_dat_o,
   output wire                          wb_ack_o,
   input  wire                          local_ready_i,
   output wire [`DDRB_LINE_AW-1:0]      local_addr_o,
   output wire                          local_read_req_o,
   output wire                          local_write_req_o,
   output wire ddr_bridge_pkg::line_t   local_wdata_o,
   output wire [31:0]                   local_be_o,
   input  wire                          local_rdata_valid_i,
   input  wire ddr_bridge_pkg::line_t   local_rdata_i
);

   import ddr_bridge_pkg::*;

   ddr_cmd_t                 cmd_in;
   ddr_cmd_t                 cmd_head;
   logic                     cmd_push;
   logic                     cmd_pop;
   logic                     cmd_empty;
   logic                     credit_ret;
   line_t                    rsp_line;
   line_t                    rsp_head;
   logic                     rsp_push;
   logic                     rsp_pop;
   logic                     rsp_empty;
   logic                     buf_valid;
   logic [`DDRB_LINE_AW-1:0] buf_tag;
   logic [`DDRB_LINE_AW-1:0] rd_tag;
   logic                     inv;

   wb_front u_front (
      .ddr_clk      (ddr_clk),
      .ddr_rst      (ddr_rst),
      .wb_req_i     (wb_req_i),
      .wb_ack_o     (wb_ack_o),
      .cmd_push_o   (cmd_push),
      .cmd_o        (cmd_in),
      .credit_ret_i (credit_ret),
      .buf_valid_i  (buf_valid),
      .buf_tag_i    (buf_tag),
      .inv_o        (inv)
   );

   // Credits stand in for the full flag
   sync_fifo #(.payload_t(ddr_cmd_t), .depth(`DDRB_CMDQ_DEPTH)) u_cmd_q (
      .ddr_clk     (ddr_clk),
      .ddr_rst     (ddr_rst),
      .push_i      (cmd_push),
      .push_data_i (cmd_in),
      .pop_i       (cmd_pop),
      .head_o      (cmd_head),
      .empty_o     (cmd_empty),
      .full_o      ()
   );

   sync_fifo #(.payload_t(line_t), .depth(`DDRB_RSPQ_DEPTH)) u_rsp_q (
      .ddr_clk     (ddr_clk),
      .ddr_rst     (ddr_rst),
      .push_i      (rsp_push),
      .push_data_i (rsp_line),
      .pop_i       (rsp_pop),
      .head_o      (rsp_head),
      .empty_o     (rsp_empty),
      .full_o      ()
   );

   rd_line_buf u_buf (
      .ddr_clk     (ddr_clk),
      .ddr_rst     (ddr_rst),
      .rsp_valid_i (!rsp_empty),
      .rsp_line_i  (rsp_head),
      .rsp_tag_i   (rd_tag),
      .rsp_pop_o   (rsp_pop),
      .inv_i       (inv),
      .lane_i      (wb_req_i.adr[4:3]),
      .buf_valid_o (buf_valid),
      .buf_tag_o   (buf_tag),
      .rd_word_o   (wb_dat_o)
   );

   ddr_seq_ctrl u_seq (
      .ddr_clk             (ddr_clk),
      .ddr_rst             (ddr_rst),
      .cmd_empty_i         (cmd_empty),
      .cmd_head_i          (cmd_head),
      .cmd_pop_o           (cmd_pop),
      .credit_ret_o        (credit_ret),
      .local_ready_i       (local_ready_i),
      .local_read_req_o    (local_read_req_o),
      .local_write_req_o   (local_write_req_o),
      .local_addr_o        (local_addr_o),
      .local_wdata_o       (local_wdata_o),
      .local_be_o          (local_be_o),
      .local_rdata_valid_i (local_rdata_valid_i),
      .local_rdata_i       (local_rdata_i),
      .rsp_push_o          (rsp_push),
      .rsp_line_o          (rsp_line),
      .rd_tag_o            (rd_tag)
   );

endmodule

`default_nettype wire

//--- hw/ddr_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module ddr_seq_ctrl (
   input  wire                          ddr_clk,
   input  wire                          ddr_rst,
   input  wire                          cmd_empty_i,
   input  wire ddr_bridge_pkg::ddr_cmd_t cmd_head_i,
   output logic                         cmd_pop_o,
   output logic                         credit_ret_o,
   input  wire                          local_ready_i,
   output logic                         local_read_req_o,
   output logic                         local_write_req_o,
   output logic [`DDRB_LINE_AW-1:0]     local_addr_o,
   output ddr_bridge_pkg::line_t        local_wdata_o,
   output logic [31:0]                  local_be_o,
   input  wire                          local_rdata_valid_i,
   input  wire ddr_bridge_pkg::line_t   local_rdata_i,
   output logic                         rsp_push_o,
   output ddr_bridge_pkg::line_t        rsp_line_o,
   output logic [`DDRB_LINE_AW-1:0]     rd_tag_o
);

   import ddr_bridge_pkg::*;

   typedef enum logic [1:0] {s_idle, s_wr_issue, s_rd_wait, s_rd_done} state_t;

   state_t   state;
   ddr_cmd_t cmd_q;      // Command being issued, stable until back in idle
   logic     rd_req_q;

   assign cmd_pop_o = (state == s_idle) && !cmd_empty_i && local_ready_i;

   //////////////////////////////
   // Local interface drive
   //////////////////////////////

   assign local_write_req_o = (state == s_wr_issue);
   assign local_read_req_o  = rd_req_q;
   assign local_addr_o      = cmd_q.line_addr;
   assign local_wdata_o     = {4{cmd_q.wdata}};                    // Same word on every lane
   assign local_be_o        = {24'd0, cmd_q.be} << {cmd_q.lane, 3'b000};

   assign rsp_push_o = (state == s_rd_wait) && local_rdata_valid_i;
   assign rsp_line_o = local_rdata_i;
   assign rd_tag_o   = cmd_q.line_addr;   // Held through s_rd_done for the buffer load

   always_ff @(posedge ddr_clk)
   begin
      if (cmd_pop_o)
         cmd_q <= cmd_head_i;
   end

   //////////////////////////////
   // Sequencer FSM
   //////////////////////////////

   always_ff @(posedge ddr_clk or posedge ddr_rst)
   begin
      if (ddr_rst)
      begin
         state        <= s_idle;
         rd_req_q     <= 1'b0;
         credit_ret_o <= 1'b0;
      end
      else
      begin
         credit_ret_o <= cmd_pop_o;   // One credit per popped entry
         case (state)
            s_idle:
            begin
               if (cmd_pop_o && cmd_head_i.is_write)
                  state <= s_wr_issue;
               else if (cmd_pop_o)
               begin
                  state    <= s_rd_wait;
                  rd_req_q <= 1'b1;
               end
            end
            s_wr_issue:
            begin
               if (local_ready_i)
                  state <= s_idle;   // Write taken this cycle
            end
            s_rd_wait:
            begin
               if (rd_req_q && local_ready_i)
                  rd_req_q <= 1'b0;
               if (local_rdata_valid_i)
                  state <= s_rd_done;
            end
            default:
               state <= s_idle;   // s_rd_done, buffer picks up the line
         endcase
      end
   end

   a_one_req: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
      !(local_read_req_o && local_write_req_o));

endmodule

`default_nettype wire

//--- hw/rd_line_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module rd_line_buf (
   input  wire                        ddr_clk,
   input  wire                        ddr_rst,
   input  wire                        rsp_valid_i,
   input  wire ddr_bridge_pkg::line_t rsp_line_i,
   input  wire [`DDRB_LINE_AW-1:0]    rsp_tag_i,
   output logic                       rsp_pop_o,
   input  wire                        inv_i,
   input  wire [1:0]                  lane_i,
   output logic                       buf_valid_o,
   output logic [`DDRB_LINE_AW-1:0]   buf_tag_o,
   output ddr_bridge_pkg::word_t      rd_word_o
);

   import ddr_bridge_pkg::*;

   line_t line_q;

   assign rsp_pop_o = rsp_valid_i;   // Take every returned line at once

   always_ff @(posedge ddr_clk or posedge ddr_rst)
   begin
      if (ddr_rst)
         buf_valid_o <= 1'b0;
      else if (rsp_pop_o)
         buf_valid_o <= 1'b1;
      else if (inv_i)
         buf_valid_o <= 1'b0;
   end

   // Returned line and its tag
   always_ff @(posedge ddr_clk)
   begin
      if (rsp_pop_o)
      begin
         line_q    <= rsp_line_i;
         buf_tag_o <= rsp_tag_i;
      end
   end

   // Word select by address bits 4:3
   always_comb
   begin
      case (lane_i)
         2'd0:    rd_word_o = line_q[63:0];
         2'd1:    rd_word_o = line_q[127:64];
         2'd2:    rd_word_o = line_q[191:128];
         default: rd_word_o = line_q[255:192];
      endcase
   end

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  wire      ddr_clk,
   input  wire      ddr_rst,
   input  wire      push_i,
   input  payload_t push_data_i,
   input  wire      pop_i,
   output payload_t head_o,
   output logic     empty_o,
   output logic     full_o
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   payload_t        mem [depth];
   logic [aw-1:0]   wr_ptr;
   logic [aw-1:0]   rd_ptr;
   logic [cw-1:0]   cnt;

   assign head_o  = mem[rd_ptr];            // Head visible while not empty
   assign empty_o = (cnt == '0);
   assign full_o  = (cnt == cw'(depth));

   // Payload storage
   always_ff @(posedge ddr_clk)
   begin
      if (push_i)
         mem[wr_ptr] <= push_data_i;
   end

   always_ff @(posedge ddr_clk or posedge ddr_rst)
   begin
      if (ddr_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         cnt <= cnt + cw'(push_i) - cw'(pop_i);
      end
   end

   // Producers keep their own count of free entries
   a_no_push_full: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
      push_i |-> !full_o);
   a_no_pop_empty: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
      pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hw/wb_front.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module wb_front (
   input  wire                       ddr_clk,
   input  wire                       ddr_rst,
   input  wire ddr_bridge_pkg::wb_req_t wb_req_i,
   output logic                      wb_ack_o,
   output logic                      cmd_push_o,
   output ddr_bridge_pkg::ddr_cmd_t  cmd_o,
   input  wire                       credit_ret_i,
   input  wire                       buf_valid_i,
   input  wire [`DDRB_LINE_AW-1:0]   buf_tag_i,
   output logic                      inv_o
);

   localparam int cred_w = $clog2(`DDRB_CMDQ_DEPTH + 1);

   logic [cred_w-1:0]        credits;
   logic                     rd_pend;   // Read miss sent, waiting for the line
   logic [`DDRB_LINE_AW-1:0] req_line;
   logic                     access;
   logic                     have_credit;
   logic                     hit;
   logic                     wr_ack;
   logic                     rd_hit;
   logic                     rd_miss_push;

   //////////////////////////////
   // Request decode
   //////////////////////////////

   assign req_line    = wb_req_i.adr[`DDRB_ADDR_W-1:5];
   assign access      = wb_req_i.cyc && wb_req_i.stb;
   assign have_credit = (credits != '0);
   assign hit         = buf_valid_i && (buf_tag_i == req_line);

   assign wr_ack       = access && wb_req_i.we && have_credit;   // Posted write
   assign rd_hit       = access && !wb_req_i.we && hit;
   assign rd_miss_push = access && !wb_req_i.we && !hit && !rd_pend && have_credit;

   assign wb_ack_o   = wr_ack || rd_hit;
   assign cmd_push_o = wr_ack || rd_miss_push;
   assign inv_o      = wr_ack && hit;    // Buffered line goes stale

   always_comb
   begin
      cmd_o.is_write  = wb_req_i.we;
      cmd_o.line_addr = req_line;
      cmd_o.lane      = wb_req_i.adr[4:3];
      cmd_o.be        = wb_req_i.sel;
      cmd_o.wdata     = wb_req_i.dat;
   end

   //////////////////////////////
   // Credits and pending read
   //////////////////////////////

   always_ff @(posedge ddr_clk or posedge ddr_rst)
   begin
      if (ddr_rst)
      begin
         credits <= cred_w'(`DDRB_CMDQ_DEPTH);   // Queue starts empty
         rd_pend <= 1'b0;
      end
      else
      begin
         credits <= credits - cred_w'(cmd_push_o) + cred_w'(credit_ret_i);
         if (rd_miss_push)
            rd_pend <= 1'b1;
         else if (rd_hit)
            rd_pend <= 1'b0;   // Line arrived and the read was acked
      end
   end

   // Sequencer never hands back more credits than were spent
   a_credit_bound: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
      credits <= cred_w'(`DDRB_CMDQ_DEPTH));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the bridge and its testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_bridge \
   -f flist.f -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log
if grep -q 'Test failures found' sim.log || ! grep -q 'All tests passed!' sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation PASSED"

//--- verif/local_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module local_mem_model (
   input  wire                        ddr_clk,
   input  wire                        ddr_rst,
   input  wire                        hold_i,        // Forces the ready line low
   output logic                       local_ready_o,
   input  wire [`DDRB_LINE_AW-1:0]    local_addr_i,
   input  wire                        local_read_req_i,
   input  wire                        local_write_req_i,
   input  wire ddr_bridge_pkg::line_t local_wdata_i,
   input  wire [31:0]                 local_be_i,
   output logic                       local_rdata_valid_o,
   output ddr_bridge_pkg::line_t      local_rdata_o,
   output int                         rd_count_o     // Read requests taken so far
);

   import ddr_bridge_pkg::*;

   localparam int lines = 64;

   line_t      mem [lines];
   integer     seed = 32'h95fcfa5b;
   logic       rd_busy;
   logic [5:0] rd_line;
   int         rd_wait;

   // Each word of the fill holds its own word address
   function automatic line_t fill_line(input int idx);
      line_t l;
      for (int w = 0; w < 4; w++)
         l[w*64 +: 64] = {32'hfeed_0000, 32'(idx*4 + w)};
      return l;
   endfunction

   always @(posedge ddr_clk or posedge ddr_rst)
   begin
      if (ddr_rst)
      begin
         local_ready_o       <= 1'b0;
         local_rdata_valid_o <= 1'b0;
         local_rdata_o       <= '0;
         rd_busy             <= 1'b0;
         rd_line             <= '0;
         rd_wait             <= 0;
         rd_count_o          <= 0;
         for (int i = 0; i < lines; i++)
            mem[i] <= fill_line(i);
      end
      else
      begin
         local_ready_o       <= !hold_i && (($random(seed) & 3) != 0);   // Gap about 1 in 4
         local_rdata_valid_o <= 1'b0;
         if (local_write_req_i && local_ready_o)
         begin
            for (int b = 0; b < 32; b++)
               if (local_be_i[b])
                  mem[local_addr_i[5:0]][b*8 +: 8] <= local_wdata_i[b*8 +: 8];
         end
         if (local_read_req_i && local_ready_o)
         begin
            rd_busy    <= 1'b1;
            rd_line    <= local_addr_i[5:0];
            rd_wait    <= 2 + ($random(seed) & 7);   // 2 to 9 cycles
            rd_count_o <= rd_count_o + 1;
         end
         else if (rd_busy)
         begin
            if (rd_wait == 1)
            begin
               local_rdata_valid_o <= 1'b1;
               local_rdata_o       <= mem[rd_line];
               rd_busy             <= 1'b0;
            end
            else
               rd_wait <= rd_wait - 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_ddr_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "ddr_bridge_consts.svh"

module tb_ddr_bridge;

   import ddr_bridge_pkg::*;

   typedef enum logic [2:0] {op_wr, op_rd, op_hold, op_release, op_wr_blocked, op_count} op_t;

   typedef struct packed {
      op_t                     op;
      logic [`DDRB_ADDR_W-1:0] adr;
      be_t                     sel;
      word_t                   dat;
      word_t                   exp;   // Read word, or read requests since the last count
   } row_t;

   logic                     ddr_clk = 1'b0;
   logic                     ddr_rst;
   wb_req_t                  wb_req;
   word_t                    wb_dat;
   logic                     wb_ack;
   logic                     hold;
   logic                     local_ready;
   logic [`DDRB_LINE_AW-1:0] local_addr;
   logic                     local_read_req;
   logic                     local_write_req;
   line_t                    local_wdata;
   logic [31:0]              local_be;
   logic                     local_rdata_valid;
   line_t                    local_rdata;
   int                       rd_count;
   row_t                     rows [$];
   word_t                    shadow [logic [`DDRB_ADDR_W-1:0]];   // Keyed by word address
   int                       count_mark;
   logic                     table_ready = 1'b0;

   always #10 ddr_clk = ~ddr_clk;

   ddr_bridge_top ddr_bridge_top_i (
      .ddr_clk             (ddr_clk),
      .ddr_rst             (ddr_rst),
      .wb_req_i            (wb_req),
      .wb_dat_o            (wb_dat),
      .wb_ack_o            (wb_ack),
      .local_ready_i       (local_ready),
      .local_addr_o        (local_addr),
      .local_read_req_o    (local_read_req),
      .local_write_req_o   (local_write_req),
      .local_wdata_o       (local_wdata),
      .local_be_o          (local_be),
      .local_rdata_valid_i (local_rdata_valid),
      .local_rdata_i       (local_rdata)
   );

   local_mem_model u_mem (
      .ddr_clk             (ddr_clk),
      .ddr_rst             (ddr_rst),
      .hold_i              (hold),
      .local_ready_o       (local_ready),
      .local_addr_i        (local_addr),
      .local_read_req_i    (local_read_req),
      .local_write_req_i   (local_write_req),
      .local_wdata_i       (local_wdata),
      .local_be_i          (local_be),
      .local_rdata_valid_o (local_rdata_valid),
      .local_rdata_o       (local_rdata),
      .rd_count_o          (rd_count)
   );

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t ns: %s, expected %h, got %h",
                                 $time, what, exp, got));
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp)
         stop_on_error($sformatf("Mismatch at %0t ns: %s, expected %0d, got %0d",
                                 $time, what, exp, got));
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t ns: %s, expected %b, got %b",
                                 $time, what, exp, got));
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   function automatic word_t byte_mask(input be_t sel);
      word_t m;
      for (int b = 0; b < 8; b++)
         m[b*8 +: 8] = {8{sel[b]}};
      return m;
   endfunction

   function automatic word_t shadow_word(input logic [`DDRB_ADDR_W-1:0] adr);
      logic [`DDRB_ADDR_W-1:0] wa;
      wa = adr >> 3;
      if (shadow.exists(wa))
         return shadow[wa];
      return {32'hfeed_0000, wa};   // Memory fill before any write
   endfunction

   function automatic void add_row(input op_t op, input logic [`DDRB_ADDR_W-1:0] adr,
                                   input be_t sel, input word_t dat, input word_t exp);
      row_t r;
      r.op  = op;
      r.adr = adr;
      r.sel = sel;
      r.dat = dat;
      r.exp = exp;
      rows.push_back(r);
   endfunction

   function automatic void write_row(input logic [`DDRB_ADDR_W-1:0] adr, input be_t sel,
                                     input word_t dat);
      word_t mask;
      mask = byte_mask(sel);
      shadow[adr >> 3] = (shadow_word(adr) & ~mask) | (dat & mask);
      add_row(op_wr, adr, sel, dat, '0);
   endfunction

   function automatic void read_row(input logic [`DDRB_ADDR_W-1:0] adr);
      add_row(op_rd, adr, 8'hff, '0, shadow_word(adr));
   endfunction

   function automatic void count_row(input int n);
      add_row(op_count, '0, '0, '0, word_t'(n));
   endfunction

   function automatic void build_table();
      logic [`DDRB_ADDR_W-1:0] a;
      // Full words on every lane of lines 1, 5 and 9, then read back
      for (int ln = 1; ln < 12; ln += 4)
         for (int w = 0; w < 4; w++)
         begin
            a = 32'(ln*32 + w*8);
            write_row(a, 8'hff, {~a, a});
         end
      for (int ln = 1; ln < 12; ln += 4)
         for (int w = 0; w < 4; w++)
            read_row(32'(ln*32 + w*8));
      count_row(3);
      // Partial byte enables
      write_row(32'h020, 8'h0f, 64'h1122_3344_5566_7788);
      write_row(32'h030, 8'hf0, 64'h99aa_bbcc_ddee_ff00);
      write_row(32'h0b8, 8'h81, 64'hdead_beef_cafe_f00d);
      write_row(32'h128, 8'h3c, 64'h0f0f_f0f0_0f0f_f0f0);   // Line 9 sits in the buffer
      read_row(32'h020);
      read_row(32'h030);
      read_row(32'h0b8);
      read_row(32'h128);
      count_row(3);
      // Hits from the line buffer, then a write makes it stale
      read_row(32'h0a0);
      read_row(32'h0a0);
      read_row(32'h0b0);
      count_row(1);
      write_row(32'h0a8, 8'hff, 64'h7777_6666_5555_4444);
      read_row(32'h0a8);
      count_row(1);
      // Controller stalled, queue fills until credits run out
      add_row(op_hold, '0, '0, '0, '0);
      for (int i = 0; i < `DDRB_CMDQ_DEPTH; i++)
      begin
         a = 32'(384 + i*8);
         write_row(a, 8'hff, {a, ~a});
      end
      add_row(op_wr_blocked, 32'h028, 8'hff, 64'hbad0_bad0_bad0_bad0, '0);
      add_row(op_release, '0, '0, '0, '0);
      for (int i = 0; i < `DDRB_CMDQ_DEPTH; i++)
         read_row(32'(384 + i*8));
      read_row(32'h028);
      count_row((`DDRB_CMDQ_DEPTH + 3) / 4 + 1);
   endfunction

   //////////////////////////////
   // Bus driver and table loop
   //////////////////////////////

   // Holds stb until ack, or for limit cycles when limit is not zero
   task automatic bus_access(input logic we, input logic [`DDRB_ADDR_W-1:0] adr,
                             input be_t sel, input word_t dat, input int limit,
                             output word_t rdata, output logic acked);
      wb_req_t req;
      int      n;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.sel = sel;
      req.dat = dat;
      acked   = 1'b0;
      rdata   = '0;
      n       = 0;
      @(posedge ddr_clk);
      wb_req <= req;
      while (!acked && (limit == 0 || n < limit))
      begin
         @(negedge ddr_clk);
         if (wb_ack)
         begin
            acked = 1'b1;
            rdata = wb_dat;
         end
         n++;
      end
      @(posedge ddr_clk);
      wb_req <= '0;
   endtask

   task automatic run_table();
      row_t  r;
      word_t got;
      logic  acked;
      for (int i = 0; i < rows.size(); i++)
      begin
         r = rows[i];
         case (r.op)
            op_wr:
               bus_access(1'b1, r.adr, r.sel, r.dat, 0, got, acked);
            op_rd:
            begin
               bus_access(1'b0, r.adr, 8'hff, '0, 0, got, acked);
               check_word($sformatf("row %0d read of %h", i, r.adr), got, r.exp);
            end
            op_hold:
            begin
               @(posedge ddr_clk);
               hold <= 1'b1;
               repeat (2) @(posedge ddr_clk);   // Ready is low from here on
            end
            op_release:
            begin
               @(posedge ddr_clk);
               hold <= 1'b0;
            end
            op_wr_blocked:
            begin
               bus_access(1'b1, r.adr, r.sel, r.dat, 20, got, acked);
               check_flag($sformatf("row %0d ack with no credit left", i), acked, 1'b0);
            end
            default:
            begin
               @(negedge ddr_clk);
               check_count($sformatf("row %0d read requests", i), rd_count - count_mark,
                           int'(r.exp[31:0]));
               count_mark = rd_count;
            end
         endcase
      end
   endtask

   initial
   begin
      ddr_rst    = 1'b1;
      wb_req     = '0;
      hold       = 1'b0;
      count_mark = 0;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge ddr_clk);
      ddr_rst <= 1'b0;
      @(negedge ddr_clk);
      check_flag("ack after reset", wb_ack, 1'b0);
      check_flag("read request after reset", local_read_req, 1'b0);
      check_flag("write request after reset", local_write_req, 1'b0);
      run_table();
      repeat (10) @(posedge ddr_clk);
      $display("All tests passed!");
      $finish;
   end

   // Watchdog, 50 cycles per table row
   initial
   begin
      wait (table_ready);
      repeat (rows.size() * 50) @(posedge ddr_clk);
      $display("Timeout: the table did not finish within %0d clock cycles", rows.size() * 50);
      $display("Test failures found");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire
